//--- dma_split_pkg.sv
// DMA packet splitter control interface
// Shared widths, types and register map

package dma_split_pkg;

  ////////////////////////////////////////
  // Bus widths
  ////////////////////////////////////////

  // Fixed AXI4-Lite geometry for this block
  localparam int AXI_ADDR_W = 5;
  localparam int AXI_DATA_W = 32;
  localparam int AXI_STRB_W = AXI_DATA_W / 8;
  localparam int AXI_RESP_W = 2;

  // Byte address on the bus
  typedef logic [AXI_ADDR_W-1:0] axi_addr_t;
  // Register or bus data word
  typedef logic [AXI_DATA_W-1:0] axi_data_t;
  // One strobe bit per byte lane
  typedef logic [AXI_STRB_W-1:0] axi_strb_t;
  // Response code on B and R
  typedef logic [AXI_RESP_W-1:0] axi_resp_t;

  // Only OKAY is ever returned
  localparam axi_resp_t RESP_OKAY = 2'b00;

  ////////////////////////////////////////
  // Register map
  ////////////////////////////////////////

  // Lowest address bit that picks a 32-bit word
  localparam int ADDR_LSB = 2;

  // Word index, address bits 4 down to 2
  typedef logic [AXI_ADDR_W-ADDR_LSB-1:0] reg_idx_t;

  // Command word to the splitter core
  localparam reg_idx_t REG_CMD      = 3'd0;
  // Status from the core, read only
  localparam reg_idx_t REG_STATUS   = 3'd1;
  // Number of packets to cut
  localparam reg_idx_t REG_NUM_PKTS = 3'd2;
  // Size of each packet
  localparam reg_idx_t REG_PKT_SIZE = 3'd3;

endpackage

//--- dma_split_regs.sv
// Splitter control register file

`timescale 1ns/1ps

module dma_split_regs
(
  input  logic                     S_AXI_ACLK,
  input  logic                     S_AXI_ARESETN,
  // Write request from the W controller
  input  logic                     wr_en,
  input  dma_split_pkg::reg_idx_t  wr_idx,
  input  dma_split_pkg::axi_data_t wr_data,
  input  dma_split_pkg::axi_strb_t wr_strb,
  // Read port for the R controller
  input  dma_split_pkg::reg_idx_t  rd_idx,
  output dma_split_pkg::axi_data_t rd_data,
  // Side band to and from the splitter core
  input  dma_split_pkg::axi_data_t status,
  output dma_split_pkg::axi_data_t cmd,
  output dma_split_pkg::axi_data_t num_pkts,
  output dma_split_pkg::axi_data_t pkt_size
);

  import dma_split_pkg::*;

  axi_data_t cmd_q;
  axi_data_t num_pkts_q;
  axi_data_t pkt_size_q;

  // Replace only the byte lanes that are strobed
  function automatic axi_data_t merge_bytes
  (
    input axi_data_t old_val,
    input axi_data_t new_val,
    input axi_strb_t strb
  );
    axi_data_t res;
    res = old_val;
    for (int i = 0; i < $bits(axi_strb_t); i++)
    begin
      if (strb[i])
        res[i*8 +: 8] = new_val[i*8 +: 8];
    end
    return res;
  endfunction

  ////////////////////////////////////////
  // Register write
  ////////////////////////////////////////

  always_ff @(posedge S_AXI_ACLK)
  begin
    if (!S_AXI_ARESETN)
    begin
      cmd_q      <= '0;
      num_pkts_q <= '0;
      pkt_size_q <= '0;
    end
    else if (wr_en)
    begin
      case (wr_idx)
        REG_CMD:      cmd_q      <= merge_bytes(cmd_q, wr_data, wr_strb);
        REG_NUM_PKTS: num_pkts_q <= merge_bytes(num_pkts_q, wr_data, wr_strb);
        REG_PKT_SIZE: pkt_size_q <= merge_bytes(pkt_size_q, wr_data, wr_strb);
        // Status and unmapped words drop the write
        default: ;
      endcase
    end
  end

  ////////////////////////////////////////
  // Read multiplexer
  ////////////////////////////////////////

  always_comb
  begin
    case (rd_idx)
      REG_CMD:      rd_data = cmd_q;
      REG_STATUS:   rd_data = status;
      REG_NUM_PKTS: rd_data = num_pkts_q;
      REG_PKT_SIZE: rd_data = pkt_size_q;
      // Words 4 to 7 read as zero
      default:      rd_data = '0;
    endcase
  end

  // Registers drive the core directly
  assign cmd      = cmd_q;
  assign num_pkts = num_pkts_q;
  assign pkt_size = pkt_size_q;

endmodule

//--- dma_split_wr_ctrl.sv
// AXI4-Lite write channel controller

`timescale 1ns/1ps

module dma_split_wr_ctrl
(
  input  logic                     S_AXI_ACLK,
  input  logic                     S_AXI_ARESETN,
  // AW channel
  input  dma_split_pkg::axi_addr_t s_axi_awaddr,
  input  logic                     s_axi_awvalid,
  output logic                     s_axi_awready,
  // W channel
  input  dma_split_pkg::axi_data_t s_axi_wdata,
  input  dma_split_pkg::axi_strb_t s_axi_wstrb,
  input  logic                     s_axi_wvalid,
  output logic                     s_axi_wready,
  // B channel
  output dma_split_pkg::axi_resp_t s_axi_bresp,
  output logic                     s_axi_bvalid,
  input  logic                     s_axi_bready,
  // Register write request
  output logic                     wr_en,
  output dma_split_pkg::reg_idx_t  wr_idx,
  output dma_split_pkg::axi_data_t wr_data,
  output dma_split_pkg::axi_strb_t wr_strb
);

  import dma_split_pkg::*;

  typedef enum logic [1:0] {WR_IDLE, WR_ACCEPT, WR_RESP} wr_state_t;

  wr_state_t state;
  wr_state_t state_nxt;
  // Word index of the write in flight
  reg_idx_t  idx_q;
  // High during the single handshake cycle
  logic      accept;

  ////////////////////////////////////////
  // State machine
  ////////////////////////////////////////

  always_comb
  begin
    state_nxt = state;
    case (state)
      // Wait until address and data are both offered
      WR_IDLE:
      begin
        if (s_axi_awvalid && s_axi_wvalid)
          state_nxt = WR_ACCEPT;
      end
      // One cycle of AWREADY/WREADY
      WR_ACCEPT: state_nxt = WR_RESP;
      // Hold the response until the master takes it
      WR_RESP:
      begin
        if (s_axi_bready)
          state_nxt = WR_IDLE;
      end
      default: state_nxt = WR_IDLE;
    endcase
  end

  always_ff @(posedge S_AXI_ACLK)
  begin
    if (!S_AXI_ARESETN)
      state <= WR_IDLE;
    else
      state <= state_nxt;
  end

  // Capture the word index as the machine leaves idle
  always_ff @(posedge S_AXI_ACLK)
  begin
    if (state == WR_IDLE && s_axi_awvalid && s_axi_wvalid)
      idx_q <= s_axi_awaddr[ADDR_LSB +: $bits(reg_idx_t)];
  end

  ////////////////////////////////////////
  // Outputs
  ////////////////////////////////////////

  assign accept        = (state == WR_ACCEPT);
  assign s_axi_awready = accept;
  assign s_axi_wready  = accept;
  assign s_axi_bvalid  = (state == WR_RESP);
  assign s_axi_bresp   = RESP_OKAY;

  // Master still holds WDATA/WSTRB in the accept cycle
  assign wr_en   = accept;
  assign wr_idx  = idx_q;
  assign wr_data = s_axi_wdata;
  assign wr_strb = s_axi_wstrb;

  // Response must stay up until taken
  a_bvalid_hold: assert property (@(posedge S_AXI_ACLK) disable iff (!S_AXI_ARESETN)
    s_axi_bvalid && !s_axi_bready |=> s_axi_bvalid)
    else $error("BVALID dropped before BREADY");

  // Address and data are always taken together
  a_ready_pair: assert property (@(posedge S_AXI_ACLK) disable iff (!S_AXI_ARESETN)
    (s_axi_awready || s_axi_wready) |-> s_axi_awvalid && s_axi_wvalid)
    else $error("AWREADY/WREADY high without both valids");

endmodule

//--- dma_split_rd_ctrl.sv
// AXI4-Lite read channel controller

`timescale 1ns/1ps

module dma_split_rd_ctrl
(
  input  logic                     S_AXI_ACLK,
  input  logic                     S_AXI_ARESETN,
  // AR channel
  input  dma_split_pkg::axi_addr_t s_axi_araddr,
  input  logic                     s_axi_arvalid,
  output logic                     s_axi_arready,
  // R channel
  output dma_split_pkg::axi_data_t s_axi_rdata,
  output dma_split_pkg::axi_resp_t s_axi_rresp,
  output logic                     s_axi_rvalid,
  input  logic                     s_axi_rready,
  // Register file read port
  output dma_split_pkg::reg_idx_t  rd_idx,
  input  dma_split_pkg::axi_data_t rd_data
);

  import dma_split_pkg::*;

  typedef enum logic [1:0] {RD_IDLE, RD_ACCEPT, RD_DATA} rd_state_t;

  rd_state_t state;
  rd_state_t state_nxt;
  // Word index of the read in flight
  reg_idx_t  idx_q;
  // Read data held for the R channel
  axi_data_t rdata_q;

  ////////////////////////////////////////
  // State machine
  ////////////////////////////////////////

  always_comb
  begin
    state_nxt = state;
    case (state)
      RD_IDLE:
      begin
        if (s_axi_arvalid)
          state_nxt = RD_ACCEPT;
      end
      // ARREADY cycle, data sampled at its end
      RD_ACCEPT: state_nxt = RD_DATA;
      RD_DATA:
      begin
        if (s_axi_rready)
          state_nxt = RD_IDLE;
      end
      default: state_nxt = RD_IDLE;
    endcase
  end

  always_ff @(posedge S_AXI_ACLK)
  begin
    if (!S_AXI_ARESETN)
      state <= RD_IDLE;
    else
      state <= state_nxt;
  end

  // Latch the word index on the first ARVALID edge
  always_ff @(posedge S_AXI_ACLK)
  begin
    if (state == RD_IDLE && s_axi_arvalid)
      idx_q <= s_axi_araddr[ADDR_LSB +: $bits(reg_idx_t)];
  end

  // Status is taken as it is during the ARREADY cycle
  always_ff @(posedge S_AXI_ACLK)
  begin
    if (!S_AXI_ARESETN)
      rdata_q <= '0;
    else if (state == RD_ACCEPT)
      rdata_q <= rd_data;
  end

  ////////////////////////////////////////
  // Outputs
  ////////////////////////////////////////

  assign rd_idx        = idx_q;
  assign s_axi_arready = (state == RD_ACCEPT);
  assign s_axi_rvalid  = (state == RD_DATA);
  assign s_axi_rdata   = rdata_q;
  assign s_axi_rresp   = RESP_OKAY;

  // Data may not move while the master stalls
  a_rdata_stable: assert property (@(posedge S_AXI_ACLK) disable iff (!S_AXI_ARESETN)
    s_axi_rvalid && !s_axi_rready |=> $stable(s_axi_rdata))
    else $error("RDATA changed under back-pressure");

endmodule

//--- dma_split_if.sv
// DMA splitter AXI4-Lite register block
// Top level

`timescale 1ns/1ps

module dma_split_if
(
  input  logic                     S_AXI_ACLK,
  input  logic                     S_AXI_ARESETN,
  // Write address channel
  input  dma_split_pkg::axi_addr_t S_AXI_AWADDR,
  input  logic                     S_AXI_AWVALID,
  output logic                     S_AXI_AWREADY,
  // Write data channel
  input  dma_split_pkg::axi_data_t S_AXI_WDATA,
  input  dma_split_pkg::axi_strb_t S_AXI_WSTRB,
  input  logic                     S_AXI_WVALID,
  output logic                     S_AXI_WREADY,
  // Write response channel
  output dma_split_pkg::axi_resp_t S_AXI_BRESP,
  output logic                     S_AXI_BVALID,
  input  logic                     S_AXI_BREADY,
  // Read address channel
  input  dma_split_pkg::axi_addr_t S_AXI_ARADDR,
  input  logic                     S_AXI_ARVALID,
  output logic                     S_AXI_ARREADY,
  // Read data channel
  output dma_split_pkg::axi_data_t S_AXI_RDATA,
  output dma_split_pkg::axi_resp_t S_AXI_RRESP,
  output logic                     S_AXI_RVALID,
  input  logic                     S_AXI_RREADY,
  // Splitter core side band
  output dma_split_pkg::axi_data_t cmd,
  input  dma_split_pkg::axi_data_t status,
  output dma_split_pkg::axi_data_t num_pkts,
  output dma_split_pkg::axi_data_t pkt_size
);

  import dma_split_pkg::*;

  // Write request into the register file
  logic      wr_en;
  reg_idx_t  wr_idx;
  axi_data_t wr_data;
  axi_strb_t wr_strb;
  // Read port of the register file
  reg_idx_t  rd_idx;
  axi_data_t rd_data;

  ////////////////////////////////////////
  // Channel controllers
  ////////////////////////////////////////

  dma_split_wr_ctrl u_wr_ctrl
  (
    .S_AXI_ACLK    (S_AXI_ACLK),
    .S_AXI_ARESETN (S_AXI_ARESETN),
    .s_axi_awaddr  (S_AXI_AWADDR),
    .s_axi_awvalid (S_AXI_AWVALID),
    .s_axi_awready (S_AXI_AWREADY),
    .s_axi_wdata   (S_AXI_WDATA),
    .s_axi_wstrb   (S_AXI_WSTRB),
    .s_axi_wvalid  (S_AXI_WVALID),
    .s_axi_wready  (S_AXI_WREADY),
    .s_axi_bresp   (S_AXI_BRESP),
    .s_axi_bvalid  (S_AXI_BVALID),
    .s_axi_bready  (S_AXI_BREADY),
    .wr_en         (wr_en),
    .wr_idx        (wr_idx),
    .wr_data       (wr_data),
    .wr_strb       (wr_strb)
  );

  dma_split_rd_ctrl u_rd_ctrl
  (
    .S_AXI_ACLK    (S_AXI_ACLK),
    .S_AXI_ARESETN (S_AXI_ARESETN),
    .s_axi_araddr  (S_AXI_ARADDR),
    .s_axi_arvalid (S_AXI_ARVALID),
    .s_axi_arready (S_AXI_ARREADY),
    .s_axi_rdata   (S_AXI_RDATA),
    .s_axi_rresp   (S_AXI_RRESP),
    .s_axi_rvalid  (S_AXI_RVALID),
    .s_axi_rready  (S_AXI_RREADY),
    .rd_idx        (rd_idx),
    .rd_data       (rd_data)
  );

  ////////////////////////////////////////
  // Register file
  ////////////////////////////////////////

  dma_split_regs u_regs
  (
    .S_AXI_ACLK    (S_AXI_ACLK),
    .S_AXI_ARESETN (S_AXI_ARESETN),
    .wr_en         (wr_en),
    .wr_idx        (wr_idx),
    .wr_data       (wr_data),
    .wr_strb       (wr_strb),
    .rd_idx        (rd_idx),
    .rd_data       (rd_data),
    .status        (status),
    .cmd           (cmd),
    .num_pkts      (num_pkts),
    .pkt_size      (pkt_size)
  );

endmodule

//--- tb_dma_split_if.sv
// DMA splitter register block testbench

`timescale 1ns/1ps

module tb_dma_split_if;

  import dma_split_pkg::*;

  // Test data table, run from the project root
  localparam string DATA_FILE = "dma_split_testdata.txt";
  localparam int CLK_PERIOD   = 40;
  localparam int RESET_CYCLES = 8;
  // Longest BREADY/RREADY stall in cycles
  localparam int BP_MAX       = 5;
  // Cycles to wait for any READY or VALID
  localparam int HS_LIMIT     = 16;
  localparam int LINE_CYCLES  = 20;

  logic      clk;
  logic      aresetn;
  axi_addr_t awaddr;
  logic      awvalid;
  logic      awready;
  axi_data_t wdata;
  axi_strb_t wstrb;
  logic      wvalid;
  logic      wready;
  axi_resp_t bresp;
  logic      bvalid;
  logic      bready;
  axi_addr_t araddr;
  logic      arvalid;
  logic      arready;
  axi_data_t rdata;
  axi_resp_t rresp;
  logic      rvalid;
  logic      rready;
  axi_data_t cmd;
  axi_data_t status;
  axi_data_t num_pkts;
  axi_data_t pkt_size;

  // Transaction table loaded from the data file
  string     t_name[$];
  string     t_op[$];
  axi_addr_t t_addr[$];
  axi_data_t t_data[$];
  axi_strb_t t_strb[$];
  axi_data_t t_status[$];
  axi_data_t t_exp[$];

  int mismatch_count = 0;
  int hs_count       = 0;
  int wd_cycles      = 0;
  bit load_done      = 1'b0;

  dma_split_if u_dma_split_if
  (
    .S_AXI_ACLK    (clk),
    .S_AXI_ARESETN (aresetn),
    .S_AXI_AWADDR  (awaddr),
    .S_AXI_AWVALID (awvalid),
    .S_AXI_AWREADY (awready),
    .S_AXI_WDATA   (wdata),
    .S_AXI_WSTRB   (wstrb),
    .S_AXI_WVALID  (wvalid),
    .S_AXI_WREADY  (wready),
    .S_AXI_BRESP   (bresp),
    .S_AXI_BVALID  (bvalid),
    .S_AXI_BREADY  (bready),
    .S_AXI_ARADDR  (araddr),
    .S_AXI_ARVALID (arvalid),
    .S_AXI_ARREADY (arready),
    .S_AXI_RDATA   (rdata),
    .S_AXI_RRESP   (rresp),
    .S_AXI_RVALID  (rvalid),
    .S_AXI_RREADY  (rready),
    .cmd           (cmd),
    .status        (status),
    .num_pkts      (num_pkts),
    .pkt_size      (pkt_size)
  );

  initial clk = 1'b0;
  always #(CLK_PERIOD / 2) clk = ~clk;

  ////////////////////////////////////////
  // Compare tasks
  ////////////////////////////////////////

  task automatic check_data(input string name, input axi_data_t exp, input axi_data_t act);
    if (act !== exp)
    begin
      $display("MISMATCH %s: expected %h, actual %h", name, exp, act);
      mismatch_count++;
    end
  endtask

  task automatic check_resp(input string name, input axi_resp_t exp, input axi_resp_t act);
    if (act !== exp)
    begin
      $display("MISMATCH %s: expected resp %h, actual resp %h", name, exp, act);
      mismatch_count++;
    end
  endtask

  ////////////////////////////////////////
  // Data file
  ////////////////////////////////////////

  task automatic load_table();
    int        fd;
    int        n;
    string     line;
    string     f_name;
    string     f_op;
    axi_addr_t f_addr;
    axi_data_t f_data;
    axi_strb_t f_strb;
    axi_data_t f_stat;
    axi_data_t f_exp;
    fd = $fopen(DATA_FILE, "r");
    if (fd == 0)
    begin
      $display("Could not open the test data file %s", DATA_FILE);
      hs_count++;
      return;
    end
    while (!$feof(fd))
    begin
      line = "";
      void'($fgets(line, fd));
      // Skip blank lines and column notes
      if (line.len() < 2 || line.substr(0, 0) == "#")
        continue;
      n = $sscanf(line, "%s %s %h %h %h %h %h",
                  f_name, f_op, f_addr, f_data, f_strb, f_stat, f_exp);
      if (n != 7)
      begin
        $display("Test data line could not be parsed: %s", line);
        hs_count++;
        continue;
      end
      t_name.push_back(f_name);
      t_op.push_back(f_op);
      t_addr.push_back(f_addr);
      t_data.push_back(f_data);
      t_strb.push_back(f_strb);
      t_status.push_back(f_stat);
      t_exp.push_back(f_exp);
    end
    $fclose(fd);
  endtask

  ////////////////////////////////////////
  // Bus transactions
  ////////////////////////////////////////

  task automatic do_write(input string name, input axi_addr_t addr, input axi_data_t data,
                          input axi_strb_t strb);
    int wait_cnt;
    int delay;
    @(posedge clk);
    awaddr  <= addr;
    awvalid <= 1'b1;
    wdata   <= data;
    wstrb   <= strb;
    wvalid  <= 1'b1;
    wait_cnt = 0;
    @(negedge clk);
    while (!awready && wait_cnt < HS_LIMIT)
    begin
      wait_cnt++;
      @(negedge clk);
    end
    if (!awready || !wready)
    begin
      $display("%s: write address and data were never accepted", name);
      hs_count++;
      return;
    end
    // Transfer edge, drop the valids
    @(posedge clk);
    awvalid <= 1'b0;
    wvalid  <= 1'b0;
    delay = $urandom % (BP_MAX + 1);
    wait_cnt = 0;
    @(negedge clk);
    while (!bvalid && wait_cnt < HS_LIMIT)
    begin
      wait_cnt++;
      @(negedge clk);
    end
    if (!bvalid)
    begin
      $display("%s: no write response arrived", name);
      hs_count++;
      return;
    end
    // Response has to wait for BREADY
    repeat (delay)
    begin
      @(negedge clk);
      if (!bvalid)
      begin
        $display("%s: BVALID dropped before BREADY was given", name);
        hs_count++;
      end
    end
    @(posedge clk);
    bready <= 1'b1;
    @(negedge clk);
    if (!bvalid)
    begin
      $display("%s: BVALID was low when BREADY was given", name);
      hs_count++;
    end
    check_resp(name, RESP_OKAY, bresp);
    @(posedge clk);
    bready <= 1'b0;
  endtask

  task automatic do_read(input string name, input axi_addr_t addr, input axi_data_t exp);
    int        wait_cnt;
    int        delay;
    @(posedge clk);
    araddr  <= addr;
    arvalid <= 1'b1;
    wait_cnt = 0;
    @(negedge clk);
    while (!arready && wait_cnt < HS_LIMIT)
    begin
      wait_cnt++;
      @(negedge clk);
    end
    if (!arready)
    begin
      $display("%s: read address was never accepted", name);
      hs_count++;
      return;
    end
    @(posedge clk);
    arvalid <= 1'b0;
    delay = $urandom % (BP_MAX + 1);
    wait_cnt = 0;
    @(negedge clk);
    while (!rvalid && wait_cnt < HS_LIMIT)
    begin
      wait_cnt++;
      @(negedge clk);
    end
    if (!rvalid)
    begin
      $display("%s: no read data arrived", name);
      hs_count++;
      return;
    end
    // Data must sit still while RREADY is low
    repeat (delay)
    begin
      @(negedge clk);
      if (!rvalid)
      begin
        $display("%s: RVALID dropped before RREADY was given", name);
        hs_count++;
      end
      check_data({name, "_hold"}, exp, rdata);
    end
    @(posedge clk);
    rready <= 1'b1;
    @(negedge clk);
    check_data(name, exp, rdata);
    check_resp(name, RESP_OKAY, rresp);
    @(posedge clk);
    rready <= 1'b0;
  endtask

  // Address picks the side-band port to look at
  task automatic check_port(input string name, input axi_addr_t addr, input axi_data_t exp);
    @(negedge clk);
    case (addr[4:2])
      3'd0:    check_data(name, exp, cmd);
      3'd2:    check_data(name, exp, num_pkts);
      3'd3:    check_data(name, exp, pkt_size);
      default:
      begin
        $display("%s: port check names no output port", name);
        hs_count++;
      end
    endcase
  endtask

  ////////////////////////////////////////
  // Watchdog
  ////////////////////////////////////////

  initial
  begin
    wait (load_done);
    repeat (wd_cycles) @(posedge clk);
    $display("Watchdog expired after %0d cycles, the run did not finish", wd_cycles);
    $display(">>> FAIL");
    $finish;
  end

  ////////////////////////////////////////
  // Main sequence
  ////////////////////////////////////////

  initial
  begin
    void'($urandom(8));
    aresetn <= 1'b0;
    awaddr  <= '0;
    awvalid <= 1'b0;
    wdata   <= '0;
    wstrb   <= '0;
    wvalid  <= 1'b0;
    bready  <= 1'b0;
    araddr  <= '0;
    arvalid <= 1'b0;
    rready  <= 1'b0;
    status  <= '0;
    load_table();
    wd_cycles = t_name.size() * LINE_CYCLES + RESET_CYCLES;
    load_done = 1'b1;
    repeat (RESET_CYCLES) @(posedge clk);
    aresetn <= 1'b1;
    foreach (t_name[i])
    begin
      // Status input for this line
      @(posedge clk);
      status <= t_status[i];
      case (t_op[i])
        "write": do_write(t_name[i], t_addr[i], t_data[i], t_strb[i]);
        "read":  do_read(t_name[i], t_addr[i], t_exp[i]);
        "port":  check_port(t_name[i], t_addr[i], t_exp[i]);
        default:
        begin
          $display("%s: unknown operation %s", t_name[i], t_op[i]);
          hs_count++;
        end
      endcase
    end
    $display("Done: %0d transactions, %0d mismatches, %0d handshake errors",
             t_name.size(), mismatch_count, hs_count);
    if (mismatch_count == 0 && hs_count == 0)
      $display(">>> PASS");
    else
      $display(">>> FAIL");
    $finish;
  end

endmodule

//--- dma_split_testdata.txt
# name op addr data strb status expected (all but name and op in hex)
# op is write, read or port; port reads cmd at 00, num_pkts at 08, pkt_size at 0c
rst_cmd       port  00 00000000 0 00000000 00000000
rst_num       port  08 00000000 0 00000000 00000000
rst_size      port  0c 00000000 0 00000000 00000000
rst_rd_cmd    read  00 00000000 0 00000000 00000000
rst_rd_num    read  08 00000000 0 00000000 00000000
rst_rd_size   read  0c 00000000 0 00000000 00000000
wr_cmd        write 00 a5a50001 f 00000000 00000000
port_cmd      port  00 00000000 0 00000000 a5a50001
rd_cmd        read  00 00000000 0 00000000 a5a50001
wr_num        write 08 00000040 f 00000000 00000000
port_num      port  08 00000000 0 00000000 00000040
wr_size       write 0c 000005dc f 00000000 00000000
rd_size       read  0c 00000000 0 00000000 000005dc
wr_cmd_b1     write 00 1234cd78 2 00000000 00000000
rd_cmd_b1     read  00 00000000 0 00000000 a5a5cd01
wr_cmd_hi     write 00 beef0000 c 00000000 00000000
port_cmd_hi   port  00 00000000 0 00000000 beefcd01
wr_size_b0    write 0c ffffff22 1 00000000 00000000
rd_size_b0    read  0c 00000000 0 00000000 00000522
wr_num_b3     write 08 7f000000 8 00000000 00000000
rd_num_b3     read  08 00000000 0 00000000 7f000040
rd_status     read  04 00000000 0 c0ffee01 c0ffee01
wr_status     write 04 ffffffff f c0ffee01 00000000
rd_status2    read  04 00000000 0 12345678 12345678
wr_word4      write 10 ffffffff f 00000000 00000000
wr_word7      write 1c deadbeef f 00000000 00000000
rd_word4      read  10 00000000 0 00000000 00000000
rd_word5      read  14 00000000 0 00000000 00000000
rd_word6      read  18 00000000 0 00000000 00000000
rd_word7      read  1c 00000000 0 00000000 00000000
port_cmd_end  port  00 00000000 0 00000000 beefcd01
port_num_end  port  08 00000000 0 00000000 7f000040
port_size_end port  0c 00000000 0 00000000 00000522

//--- Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -j 0
TOP       = tb_dma_split_if
FILELIST  = all.f

SIM = obj_dir/V$(TOP)

.PHONY: compile run clean

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

run: compile
	@out="$$(./$(SIM))"; \
	echo "$$out"; \
	echo "$$out" | grep -qxF '>>> PASS'

clean:
	rm -rf obj_dir

//--- all.f
dma_split_pkg.sv
dma_split_regs.sv
dma_split_wr_ctrl.sv
dma_split_rd_ctrl.sv
dma_split_if.sv
tb_dma_split_if.sv
